//--- cbuf_to_ddr3.f
+incdir+source
source/cbuf_pkg.sv
source/acq_counters.sv
source/acq_dat_mux.sv
source/cbuf_to_ddr3_sm.sv
source/cbuf_to_ddr3.sv
dv/cbuf_to_ddr3_chk.sv
dv/cbuf_to_ddr3_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cbuf_to_ddr3.f --top-module cbuf_to_ddr3_tb -Mdir obj_dir -o cbuf_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cbuf_sim 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- dv/cbuf_to_ddr3_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module cbuf_to_ddr3_tb
    import cbuf_pkg::*;
;
    localparam int NUM_FILLS      = 4;
    localparam int NUM_TRIG       = 6;   // triggers per fill
    localparam int MAX_BURSTS     = 6;
    localparam int TIMEOUT_CYCLES = NUM_FILLS * NUM_TRIG * (MAX_BURSTS + 2) * 8 + 2000;

    logic adc_clk, reset, cbuf_rd_en, cbuf_trig_en, initial_fill_num_wr, trig_fifo_empty;
    logic [11:0]              channel_tag;
    logic [`FILL_NUM_W-1:0]   initial_fill_num, fill_num;
    logic [`NUM_BURSTS_W-1:0] num_bursts;
    logic [`CBUF_ADDR_W-1:0]  pre_trig, circ_buf_trig_addr, circ_buf_rd_addr;
    logic [`CBUF_DAT_W-1:0]   circ_buf_rd_dat;
    logic [`TRIG_TIME_W-1:0]  trigger_time;
    logic [`ACQ_OUT_W-1:0]    acq_out_dat;
    logic [`WFM_NUM_W-1:0]    current_waveform_num;
    logic cbuf_rd_trig_wait, trig_addr_rd_en, acq_out_valid, ddr3_wr_active;

    logic [`CBUF_ADDR_W-1:0] trig_q[$];   // FWFT FIFO contents
    logic [`CBUF_ADDR_W-1:0] sent_q[$];   // triggers the model has yet to serve
    logic [`ACQ_OUT_W-1:0]   exp_q[$];    // expected record stream
    logic [127:0]            m_cksum;
    logic [`WFM_NUM_W-1:0]   m_wfm, m_badr;
    logic [`FILL_NUM_W-1:0]  m_fill;
    logic [`CBUF_ADDR_W-1:0] last_addr;   // address presented last cycle
    logic                    pop_seen;
    logic                    wait_d = 1'b0;  // cbuf_rd_trig_wait one cycle back
    int data_left = 0;                       // data records of the waveform still to appear
    int errors = 0, checked = 0, cycles = 0, fills_seen = 0;
    int unsigned r;

    cbuf_to_ddr3 u_cbuf_to_ddr3 (.*);

    initial begin
        adc_clk = 1'b0;
        forever #4 adc_clk = ~adc_clk;  // 8 ns
    end

    //////////////////////////////////////////////////////////////////////
    // buffer word for an address, every address bit matters
    function automatic logic [`CBUF_DAT_W-1:0] scramble(input logic [`CBUF_ADDR_W-1:0] a);
        return {a[9:0], a} ^ 26'h2b3c5d7;
    endfunction

    function automatic string tag_name(input logic [3:0] t);
        case (t)
            TAG_FILL_HDR: return "fill_hdr";
            TAG_WFM_HDR:  return "wfm_hdr";
            TAG_DATA:     return "data";
            TAG_CHECKSUM: return "checksum";
            default:      return "bad_tag";
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [`ACQ_OUT_W-1:0] exp_val,
                               input logic [`ACQ_OUT_W-1:0] act_val);
        if (exp_val !== act_val) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic drive_fifo();
        trig_fifo_empty = (trig_q.size() == 0);
        if (trig_q.size() != 0)
            circ_buf_trig_addr = trig_q[0];  // head falls through
    endtask

    // one falling edge: FIFO pop, buffer read data, trigger time
    task automatic next_cycle();
        int unsigned lo;
        @(negedge adc_clk);
        if (pop_seen)
            trig_q.delete(0);
        circ_buf_rd_dat = scramble(last_addr);  // one cycle read latency
        last_addr       = circ_buf_rd_addr;
        if (cbuf_rd_trig_wait) begin
            r  = $urandom;
            lo = $urandom;
            trigger_time = {r[9:0], lo};
        end
        drive_fifo();
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    task automatic add_record(input logic [3:0] tag, input logic [127:0] pl);
        exp_q.push_back({tag, pl});
        m_cksum = m_cksum ^ pl;
        m_badr  = m_badr + 23'd1;    // one burst address per record
    endtask

    task automatic model_open();
        m_wfm   = '0;
        m_badr  = 23'd1;             // fill header owns address 0
        m_cksum = '0;
    endtask

    task automatic model_waveform(input logic [`CBUF_ADDR_W-1:0] trig_addr,
                                  input logic [`TRIG_TIME_W-1:0] ttime);
        logic [127:0]            pl;
        logic [`CBUF_ADDR_W-1:0] a;
        pl = '0;
        pl[22:0]   = m_wfm;
        pl[54:32]  = m_badr;
        pl[105:64] = ttime;
        add_record(TAG_WFM_HDR, pl);
        m_wfm = m_wfm + 23'd1;
        a = trig_addr - pre_trig;    // wraps mod 2^16
        for (int b = 0; b < int'(num_bursts); b++) begin
            pl = '0;
            for (int w = 0; w < 4; w++) begin
                pl[26*w +: 26] = scramble(a);  // oldest word lowest
                a = a + 16'd1;
            end
            add_record(TAG_DATA, pl);
        end
    endtask

    task automatic model_close();
        logic [127:0] pl;
        add_record(TAG_CHECKSUM, m_cksum);
        pl = '0;
        pl[23:0]  = m_fill;
        pl[54:32] = m_badr;          // record count incl. this header
        pl[75:64] = channel_tag;
        add_record(TAG_FILL_HDR, pl);
        m_fill = m_fill + 24'd1;
    endtask

    task automatic load_fill_num();
        r = $urandom;
        initial_fill_num    = r[23:0];
        initial_fill_num_wr = 1'b1;
        next_cycle();
        initial_fill_num_wr = 1'b0;
        repeat (3) next_cycle();     // two-stage synchronizer plus load
        m_fill = initial_fill_num;
        check_equal("fill_num load", 132'(m_fill), 132'(fill_num));
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor: pops, records, watchdog
    always @(posedge adc_clk) begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("errors: %0d, records checked: %0d", errors + 1, checked);
            $display("Regression failed");
            $finish;
        end else begin
            if (!reset && trig_addr_rd_en) begin
                if (!cbuf_trig_en || !cbuf_rd_en || trig_fifo_empty) begin
                    errors++;
                    $display("trigger popped while popping was not allowed");
                end
                check_equal("trig_wait before pop", 132'(1), 132'(wait_d));
                check_equal("waveform_num", 132'(m_wfm), 132'(current_waveform_num));
                if (sent_q.size() == 0) begin
                    errors++;
                    $display("trigger popped with no trigger queued");
                end else
                    model_waveform(sent_q.pop_front(), trigger_time);
                data_left = int'(num_bursts);  // busy until the last data record
            end
            if (!reset) begin
                check_equal("ddr3_wr_active", 132'(data_left != 0), 132'(ddr3_wr_active));
                if (data_left != 0)
                    check_equal("trig_wait in waveform", 132'(0), 132'(cbuf_rd_trig_wait));
            end
            if (!reset && acq_out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("record %h written with none expected", acq_out_dat);
                end else begin
                    check_equal(tag_name(exp_q[0][131:128]), exp_q[0], acq_out_dat);
                    exp_q.delete(0);
                    checked++;
                end
                if (acq_out_dat[131:128] == TAG_FILL_HDR)
                    fills_seen++;
                if (acq_out_dat[131:128] == TAG_DATA && data_left != 0)
                    data_left--;
            end
            pop_seen <= trig_addr_rd_en;
            wait_d = cbuf_rd_trig_wait;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    initial begin
        int                      pushed;
        logic [`CBUF_ADDR_W-1:0] t;
        r = $urandom(45);            // fixed seed
        reset = 1'b1;
        cbuf_rd_en = 1'b0;
        cbuf_trig_en = 1'b0;
        channel_tag = '0;
        initial_fill_num = '0;
        initial_fill_num_wr = 1'b0;
        num_bursts = 14'd1;
        pre_trig = '0;
        circ_buf_rd_dat = '0;
        circ_buf_trig_addr = '0;
        trig_fifo_empty = 1'b1;
        trigger_time = '0;
        last_addr = '0;
        pop_seen = 1'b0;
        m_fill = '0;
        model_open();
        repeat (16) next_cycle();
        reset = 1'b0;
        for (int f = 0; f < NUM_FILLS; f++) begin
            if (f % 2 == 0)
                load_fill_num();     // reload on some fills only
            r = $urandom;
            channel_tag = r[11:0];
            pre_trig    = {4'd0, r[23:12]};
            r = $urandom;
            num_bursts  = 14'(r % 6) + 14'd1;
            next_cycle();
            cbuf_rd_en   = 1'b1;     // opens the fill
            cbuf_trig_en = 1'b1;
            model_open();
            pushed = 0;
            while (pushed < NUM_TRIG) begin
                next_cycle();
                r = $urandom;
                if (r[1:0] == 2'd0)
                    cbuf_trig_en = !cbuf_trig_en;  // random enable toggling
                if (r[4:2] == 3'd0) begin
                    t = (pushed % 3 == 0) ? pre_trig - 16'd2 : r[31:16];  // wrap case
                    trig_q.push_back(t);
                    sent_q.push_back(t);
                    drive_fifo();
                    pushed++;
                end
            end
            cbuf_trig_en = 1'b1;
            while (trig_q.size() != 0)
                next_cycle();        // drain the FIFO
            cbuf_rd_en = 1'b0;       // close after the waveform in progress
            model_close();
            while (fills_seen < f + 1)
                next_cycle();
            check_equal("fill_num step", 132'(m_fill), 132'(fill_num));
        end
        repeat (8) next_cycle();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected records never appeared", exp_q.size());
        end
        if (sent_q.size() != 0) begin
            errors++;
            $display("%0d queued triggers were never served", sent_q.size());
        end
        errors += int'(u_cbuf_to_ddr3.u_chk.fail_cnt);
        $display("errors: %0d, records checked: %0d", errors, checked);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cbuf_to_ddr3_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module cbuf_to_ddr3_chk
    import cbuf_pkg::*;
(
    input logic                  adc_clk,
    input logic                  reset,
    input logic                  trig_fifo_empty,
    input logic                  trig_addr_rd_en,
    input logic                  cbuf_rd_trig_wait,
    input logic                  ddr3_wr_active,
    input logic                  acq_out_valid,
    input logic [`ACQ_OUT_W-1:0] acq_out_dat,
    input sm_state_t             state          // sequencer state from u_sm
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    // pop only against a non-empty FWFT FIFO, seen non-empty in the wait cycle too
    a_pop_not_empty: assert property (@(posedge adc_clk) disable iff (reset)
        trig_addr_rd_en |-> (!trig_fifo_empty &&
                             $past(cbuf_rd_trig_wait && !trig_fifo_empty)))
        else begin $error("trigger FIFO popped while empty"); fail_cnt++; end

    // every record carries one of the four tags
    a_valid_tag: assert property (@(posedge adc_clk) disable iff (reset)
        acq_out_valid |-> (acq_out_dat[`ACQ_OUT_W-1 -: 4] inside
            {TAG_FILL_HDR, TAG_WFM_HDR, TAG_DATA, TAG_CHECKSUM}))
        else begin $error("record written with an undefined tag"); fail_cnt++; end

    // quiet outputs and idle state after a reset edge
    a_reset_quiet: assert property (@(posedge adc_clk)
        reset |=> (!acq_out_valid && !trig_addr_rd_en && !ddr3_wr_active &&
                   !cbuf_rd_trig_wait && state == S_IDLE))
        else begin $error("outputs active during reset"); fail_cnt++; end

endmodule

bind cbuf_to_ddr3 cbuf_to_ddr3_chk u_chk (
    .adc_clk(adc_clk), .reset(reset), .trig_fifo_empty(trig_fifo_empty),
    .trig_addr_rd_en(trig_addr_rd_en), .cbuf_rd_trig_wait(cbuf_rd_trig_wait),
    .ddr3_wr_active(ddr3_wr_active), .acq_out_valid(acq_out_valid),
    .acq_out_dat(acq_out_dat), .state(u_sm.state)
);

`default_nettype wire

//--- source/cbuf_to_ddr3.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module cbuf_to_ddr3
    import cbuf_pkg::*;
(
    input  logic                      adc_clk,
    input  logic                      reset,
    input  logic                      cbuf_rd_en,          // fill in progress, low closes it
    input  logic                      cbuf_trig_en,        // new waveforms allowed
    input  logic [11:0]               channel_tag,         // goes into the fill header
    input  logic [`FILL_NUM_W-1:0]    initial_fill_num,
    input  logic                      initial_fill_num_wr, // foreign clock domain
    input  logic [`NUM_BURSTS_W-1:0]  num_bursts,          // data records per waveform
    input  logic [`CBUF_ADDR_W-1:0]   pre_trig,            // words kept before the trigger
    input  logic [`CBUF_DAT_W-1:0]    circ_buf_rd_dat,
    input  logic [`CBUF_ADDR_W-1:0]   circ_buf_trig_addr,  // FWFT head
    input  logic                      trig_fifo_empty,
    input  logic [`TRIG_TIME_W-1:0]   trigger_time,
    output logic                      cbuf_rd_trig_wait,
    output logic                      trig_addr_rd_en,
    output logic [`FILL_NUM_W-1:0]    fill_num,
    output logic [`CBUF_ADDR_W-1:0]   circ_buf_rd_addr,
    output logic [`ACQ_OUT_W-1:0]     acq_out_dat,
    output logic                      acq_out_valid,
    output logic [`WFM_NUM_W-1:0]     current_waveform_num,
    output logic                      ddr3_wr_active
);

    logic fill_open, init_rd_addr, inc_rd_addr, latch_dat, save_start_adr;
    logic burst_cntr_load, burst_cntr_zero, record_wr, wfm_done, fill_done;
    acq_sel_t acq_sel;

    logic [`CBUF_ADDR_W-1:0] circ_buf_start_addr;
    logic [`TRIG_TIME_W-1:0] wfm_trigger_time;    // time stamp of the popped trigger
    logic [`WFM_NUM_W-1:0]   burst_adr;
    logic [`WFM_NUM_W-1:0]   waveform_start_adr;  // burst address of the wfm header
    logic [`CBUF_DAT_W-1:0]  dat3, dat2, dat1, dat0;

    //////////////////////////////////////////////////////////////////////
    // trigger capture, start address and read address counter
    always_ff @(posedge adc_clk) begin
        if (trig_addr_rd_en) begin
            circ_buf_start_addr <= circ_buf_trig_addr - pre_trig; // wraps mod 2^16
            wfm_trigger_time    <= trigger_time;
        end
        if (save_start_adr)
            waveform_start_adr <= burst_adr;  // header lands at this address
    end

    always_ff @(posedge adc_clk) begin
        if (reset)
            circ_buf_rd_addr <= '0;
        else if (init_rd_addr)
            circ_buf_rd_addr <= circ_buf_start_addr;
        else if (inc_rd_addr)
            circ_buf_rd_addr <= circ_buf_rd_addr + 1'b1;  // rolls over with the buffer
    end

    // four-word shift register, newest word enters at dat3
    always_ff @(posedge adc_clk) begin
        if (latch_dat) begin
            dat3 <= circ_buf_rd_dat;
            dat2 <= dat3;
            dat1 <= dat2;
            dat0 <= dat1;  // oldest word
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instances
    cbuf_to_ddr3_sm u_sm (
        .adc_clk(adc_clk), .reset(reset), .cbuf_rd_en(cbuf_rd_en),
        .cbuf_trig_en(cbuf_trig_en), .trig_fifo_empty(trig_fifo_empty),
        .burst_cntr_zero(burst_cntr_zero), .cbuf_rd_trig_wait(cbuf_rd_trig_wait),
        .trig_addr_rd_en(trig_addr_rd_en), .fill_open(fill_open),
        .init_rd_addr(init_rd_addr), .inc_rd_addr(inc_rd_addr), .latch_dat(latch_dat),
        .save_start_adr(save_start_adr), .burst_cntr_load(burst_cntr_load),
        .record_wr(record_wr), .acq_sel(acq_sel), .wfm_done(wfm_done),
        .fill_done(fill_done), .ddr3_wr_active(ddr3_wr_active)
    );

    acq_dat_mux u_mux (
        .adc_clk(adc_clk), .reset(reset), .acq_sel(acq_sel), .record_wr(record_wr),
        .checksum_clear(fill_open), .dat3(dat3), .dat2(dat2), .dat1(dat1), .dat0(dat0),
        .channel_tag(channel_tag), .fill_num(fill_num),
        .current_waveform_num(current_waveform_num),
        .waveform_start_adr(waveform_start_adr), .burst_adr(burst_adr),
        .wfm_trigger_time(wfm_trigger_time), .acq_out_dat(acq_out_dat),
        .acq_out_valid(acq_out_valid)
    );

    acq_counters u_cntrs (
        .adc_clk(adc_clk), .reset(reset), .initial_fill_num(initial_fill_num),
        .initial_fill_num_wr(initial_fill_num_wr), .fill_open(fill_open),
        .record_wr(record_wr), .burst_cntr_load(burst_cntr_load), .num_bursts(num_bursts),
        .wfm_done(wfm_done), .fill_done(fill_done), .fill_num(fill_num),
        .current_waveform_num(current_waveform_num), .burst_adr(burst_adr),
        .burst_cntr_zero(burst_cntr_zero)
    );

endmodule

`default_nettype wire

//--- source/cbuf_to_ddr3_sm.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module cbuf_to_ddr3_sm
    import cbuf_pkg::*;
(
    input  logic     adc_clk,
    input  logic     reset,
    input  logic     cbuf_rd_en,
    input  logic     cbuf_trig_en,
    input  logic     trig_fifo_empty,
    input  logic     burst_cntr_zero,    // all data records of the waveform written
    output logic     cbuf_rd_trig_wait,
    output logic     trig_addr_rd_en,
    output logic     fill_open,          // clears checksum and counters
    output logic     init_rd_addr,
    output logic     inc_rd_addr,
    output logic     latch_dat,
    output logic     save_start_adr,
    output logic     burst_cntr_load,
    output logic     record_wr,          // mux registers a record next edge
    output acq_sel_t acq_sel,
    output logic     wfm_done,
    output logic     fill_done,
    output logic     ddr3_wr_active
);

    sm_state_t state, state_nxt;
    logic      pop_ok;

    // pop only with a trigger waiting and both enables up
    assign pop_ok = cbuf_rd_en && cbuf_trig_en && !trig_fifo_empty;

    always_ff @(posedge adc_clk) begin
        if (reset)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    // data loop per burst: RD0/DWR present the first address, RD1..LAT
    // latch one word each, DWR writes the record, 5 cycles per record
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:     if (cbuf_rd_en) state_nxt = S_OPEN;
            S_OPEN:     state_nxt = S_WAIT;
            S_WAIT: begin
                if (!cbuf_rd_en)
                    state_nxt = S_CHKSUM;                  // close the fill
                else if (cbuf_trig_en && !trig_fifo_empty)
                    state_nxt = S_POP;
            end
            S_POP:      state_nxt = pop_ok ? S_HDR : S_WAIT; // enable may have dropped
            S_HDR:      state_nxt = S_RD0;
            S_RD0:      state_nxt = S_RD1;
            S_RD1:      state_nxt = burst_cntr_zero ? S_WAIT : S_RD2;  // last record gone
            S_RD2:      state_nxt = S_RD3;
            S_RD3:      state_nxt = S_LAT;
            S_LAT:      state_nxt = S_DWR;
            S_DWR:      state_nxt = S_RD1;                 // doubles as next RD0
            S_CHKSUM:   state_nxt = S_FILL_HDR;
            S_FILL_HDR: state_nxt = S_IDLE;
            default:    state_nxt = S_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // decoded strobes
    assign cbuf_rd_trig_wait = (state == S_WAIT);
    assign trig_addr_rd_en   = (state == S_POP) && pop_ok;
    assign save_start_adr    = trig_addr_rd_en;   // burst_adr is the header's address here
    assign fill_open         = (state == S_OPEN);
    assign init_rd_addr      = (state == S_HDR);  // start addr valid the cycle after pop
    assign burst_cntr_load   = (state == S_HDR);  // load wins over the header's record_wr

    assign inc_rd_addr = state inside {S_RD0, S_RD1, S_RD2, S_RD3, S_DWR};
    assign latch_dat   = state inside {S_RD1, S_RD2, S_RD3, S_LAT}; // one cycle read latency
    assign record_wr   = state inside {S_HDR, S_DWR, S_CHKSUM, S_FILL_HDR};

    assign wfm_done  = (state == S_RD1) && burst_cntr_zero;
    assign fill_done = (state == S_FILL_HDR);      // fill number steps after its header

    // busy from the pop through the data loop
    assign ddr3_wr_active = trig_addr_rd_en ||
                            (state inside {S_HDR, S_RD0, S_RD1, S_RD2, S_RD3, S_LAT, S_DWR});

    always_comb begin
        case (state)
            S_HDR:      acq_sel = SEL_WFM_HDR;
            S_CHKSUM:   acq_sel = SEL_CHECKSUM;
            S_FILL_HDR: acq_sel = SEL_FILL_HDR;
            default:    acq_sel = SEL_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- source/acq_dat_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module acq_dat_mux
    import cbuf_pkg::*;
(
    input  logic                     adc_clk,
    input  logic                     reset,
    input  acq_sel_t                 acq_sel,
    input  logic                     record_wr,
    input  logic                     checksum_clear,  // start of fill
    input  logic [`CBUF_DAT_W-1:0]   dat3,            // newest word
    input  logic [`CBUF_DAT_W-1:0]   dat2,
    input  logic [`CBUF_DAT_W-1:0]   dat1,
    input  logic [`CBUF_DAT_W-1:0]   dat0,            // oldest word
    input  logic [11:0]              channel_tag,
    input  logic [`FILL_NUM_W-1:0]   fill_num,
    input  logic [`WFM_NUM_W-1:0]    current_waveform_num,
    input  logic [`WFM_NUM_W-1:0]    waveform_start_adr,
    input  logic [`WFM_NUM_W-1:0]    burst_adr,       // record count at fill header time
    input  logic [`TRIG_TIME_W-1:0]  wfm_trigger_time,
    output logic [`ACQ_OUT_W-1:0]    acq_out_dat,
    output logic                     acq_out_valid
);

    localparam int PAYLOAD_W = `ACQ_OUT_W - 4;

    logic [PAYLOAD_W-1:0] payload;
    logic [PAYLOAD_W-1:0] checksum;  // xor of the fill's records so far
    acq_tag_t             tag;

    //////////////////////////////////////////////////////////////////////
    // payload select, unused bits stay zero
    always_comb begin
        payload = '0;
        case (acq_sel)
            SEL_DATA: begin
                payload[103:0] = {dat3, dat2, dat1, dat0};  // read order, oldest low
                tag            = TAG_DATA;
            end
            SEL_WFM_HDR: begin
                payload[22:0]  = current_waveform_num;
                payload[54:32] = waveform_start_adr;
                payload[105:64] = wfm_trigger_time;
                tag            = TAG_WFM_HDR;
            end
            SEL_CHECKSUM: begin
                payload = checksum;
                tag     = TAG_CHECKSUM;
            end
            default: begin                      // fill header
                payload[23:0]  = fill_num;
                payload[54:32] = burst_adr;
                payload[75:64] = channel_tag;
                tag            = TAG_FILL_HDR;
            end
        endcase
    end

    // only headers and data feed the checksum
    always_ff @(posedge adc_clk) begin
        if (checksum_clear)
            checksum <= '0;
        else if (record_wr && (acq_sel == SEL_DATA || acq_sel == SEL_WFM_HDR))
            checksum <= checksum ^ payload;
    end

    // output record register
    always_ff @(posedge adc_clk) begin
        if (record_wr)
            acq_out_dat <= {tag, payload};
        if (reset)
            acq_out_valid <= 1'b0;
        else
            acq_out_valid <= record_wr;  // one cycle per record
    end

endmodule

`default_nettype wire

//--- source/acq_counters.sv
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_config.svh"

module acq_counters (
    input  logic                      adc_clk,
    input  logic                      reset,
    input  logic [`FILL_NUM_W-1:0]    initial_fill_num,
    input  logic                      initial_fill_num_wr,  // async strobe
    input  logic                      fill_open,
    input  logic                      record_wr,
    input  logic                      burst_cntr_load,
    input  logic [`NUM_BURSTS_W-1:0]  num_bursts,
    input  logic                      wfm_done,
    input  logic                      fill_done,
    output logic [`FILL_NUM_W-1:0]    fill_num,
    output logic [`WFM_NUM_W-1:0]     current_waveform_num,
    output logic [`WFM_NUM_W-1:0]     burst_adr,
    output logic                      burst_cntr_zero
);

    logic                     fill_wr_meta, fill_wr_sync;  // two-stage synchronizer
    logic [`NUM_BURSTS_W-1:0] burst_cnt;

    //////////////////////////////////////////////////////////////////////
    // fill number, load from the other domain wins over the increment
    always_ff @(posedge adc_clk) begin
        if (reset) begin
            fill_wr_meta <= 1'b0;
            fill_wr_sync <= 1'b0;
            fill_num     <= '0;
        end else begin
            fill_wr_meta <= initial_fill_num_wr;
            fill_wr_sync <= fill_wr_meta;
            if (fill_wr_sync)
                fill_num <= initial_fill_num;
            else if (fill_done)
                fill_num <= fill_num + 1'b1;   // once per closed fill
        end
    end

    // waveform number and burst address restart with every fill
    always_ff @(posedge adc_clk) begin
        if (reset) begin
            current_waveform_num <= '0;
            burst_adr            <= '0;
        end else begin
            if (fill_open)
                current_waveform_num <= '0;
            else if (wfm_done)
                current_waveform_num <= current_waveform_num + 1'b1;
            if (fill_open)
                burst_adr <= 'd1;              // address 0 is the fill header
            else if (record_wr)
                burst_adr <= burst_adr + 1'b1;
        end
    end

    // data records left in this waveform, holds at zero
    always_ff @(posedge adc_clk) begin
        if (reset) begin
            burst_cnt       <= '0;
            burst_cntr_zero <= 1'b1;
        end else if (burst_cntr_load) begin
            burst_cnt       <= num_bursts;
            burst_cntr_zero <= (num_bursts == '0);
        end else if (record_wr && !burst_cntr_zero) begin
            burst_cnt       <= burst_cnt - 1'b1;
            burst_cntr_zero <= (burst_cnt == 'd1);
        end
    end

endmodule

`default_nettype wire

//--- source/cbuf_pkg.sv
`default_nettype none

package cbuf_pkg;

    // sequencer states
    typedef enum logic [3:0] {
        S_IDLE, S_OPEN, S_WAIT, S_POP, S_HDR,
        S_RD0, S_RD1, S_RD2, S_RD3, S_LAT, S_DWR,
        S_CHKSUM, S_FILL_HDR
    } sm_state_t;

    // payload select from the state machine to the mux
    typedef enum logic [1:0] {
        SEL_FILL_HDR, SEL_WFM_HDR, SEL_DATA, SEL_CHECKSUM
    } acq_sel_t;

    // record tag, top nibble of every record
    typedef enum logic [3:0] {
        TAG_FILL_HDR = 4'd1,
        TAG_WFM_HDR  = 4'd2,
        TAG_DATA     = 4'd3,
        TAG_CHECKSUM = 4'd4
    } acq_tag_t;

endpackage

`default_nettype wire

//--- source/cbuf_config.svh
`ifndef CBUF_CONFIG_SVH
`define CBUF_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// widths shared by the sequencer and its testbench
//////////////////////////////////////////////////////////////////////

`define CBUF_ADDR_W   16   // circular buffer address
`define CBUF_DAT_W    26   // one buffer word, two samples plus range bits
`define ACQ_OUT_W     132  // 4-bit tag + 128-bit payload

`define FILL_NUM_W    24   // fill number
`define WFM_NUM_W     23   // waveform number, also the burst address
`define NUM_BURSTS_W  14   // data records per waveform
`define TRIG_TIME_W   42   // trigger time stamp

`endif
